// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_pma_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+logic
logic/pma_pkg.sv
logic/pma_status_if.sv
logic/pma_region_cfg.sv
logic/pma_match.sv
logic/pma_event_monitor.sv
logic/pma_top.sv
verif/tb_pma_top.sv

// ==== logic/pma_event_monitor.sv ====
// --------------------
// PMA event monitor
// Six wrapping counters fed from the status
// interface, with clear and select readout
// --------------------
`timescale 1ns/100ps
`default_nettype none

`include "pma_settings.svh"

module pma_event_monitor (
  input  wire                    clk,
  input  wire                    rst_n,

  // Counter control
  input  wire                    cnt_clear_i,
  input  wire pma_pkg::evt_sel_t cnt_sel_i,

  pma_status_if.observer         status,

  output pma_pkg::evt_cnt_t      cnt_value_o
);
  import pma_pkg::*;

  logic [`PMA_EVT_NUM-1:0] evt_hit;
  evt_cnt_t                cnt_q [`PMA_EVT_NUM];

  // Event classes of the status on the bus
  always_comb begin
    evt_hit                 = '0;
    evt_hit[EVT_ACCEPTED]   = 1'b1;
    evt_hit[EVT_NO_MATCH]   = !status.have_match;
    evt_hit[EVT_MULTI]      = is_multi(status.match_list);
    evt_hit[EVT_DENIED]     = !status.allow;
    evt_hit[EVT_MISALIGNED] = status.misaligned;
    evt_hit[EVT_STORE]      = status.is_store;
  end

  // Clear wins over any increment in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `PMA_EVT_NUM; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (cnt_clear_i) begin
      for (int i = 0; i < `PMA_EVT_NUM; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (status.valid) begin
      for (int i = 0; i < `PMA_EVT_NUM; i++) begin
        if (evt_hit[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;   // wraps at full scale
        end
      end
    end
  end

  // Readout straight from the counter registers
  always_comb begin
    case (cnt_sel_i)
      EVT_ACCEPTED:   cnt_value_o = cnt_q[EVT_ACCEPTED];
      EVT_NO_MATCH:   cnt_value_o = cnt_q[EVT_NO_MATCH];
      EVT_MULTI:      cnt_value_o = cnt_q[EVT_MULTI];
      EVT_DENIED:     cnt_value_o = cnt_q[EVT_DENIED];
      EVT_MISALIGNED: cnt_value_o = cnt_q[EVT_MISALIGNED];
      EVT_STORE:      cnt_value_o = cnt_q[EVT_STORE];
      default:        cnt_value_o = '0;
    endcase
  end

endmodule : pma_event_monitor

`default_nettype wire

// ==== logic/pma_match.sv ====
// --------------------
// PMA match stage
// Acceptance, region match and priority pick,
// alignment and allow decision, status register
// --------------------
`timescale 1ns/100ps
`default_nettype none

`include "pma_settings.svh"

module pma_match (
  input  wire                   clk,
  input  wire                   rst_n,

  // Data side transaction
  input  wire                   trans_valid_i,
  input  wire pma_pkg::addr_t   trans_addr_i,
  input  wire [1:0]             trans_size_i,
  input  wire                   trans_we_i,
  output logic                  trans_ready_o,

  // Table state and its write strobe
  input  wire                   cfg_we_i,
  input  wire pma_pkg::addr_t   region_base_i [`PMA_NUM_REGIONS],
  input  wire pma_pkg::addr_t   region_mask_i [`PMA_NUM_REGIONS],
  input  wire pma_pkg::attr_t   region_attr_i [`PMA_NUM_REGIONS],

  pma_status_if.producer        status
);
  import pma_pkg::*;

  logic        accept;
  match_list_t match_list;
  logic        have_match;
  region_idx_t match_idx;
  attr_t       match_attr;
  logic        misaligned;
  logic        allow;

  // Hold off new transactions while the table is rewritten
  assign trans_ready_o = !cfg_we_i;
  assign accept        = trans_valid_i && trans_ready_o;

  // Per region hit
  always_comb begin
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      match_list[i] = region_attr_i[i][`PMA_ATTR_VALID] &&
                      ((trans_addr_i & region_mask_i[i]) == region_base_i[i]);
    end
  end

  assign have_match = |match_list;

  // Lowest numbered hit wins, so scan downwards and let the last hit stick
  // No hit leaves the attributes at zero (I/O, nothing else set)
  always_comb begin
    match_idx  = '0;
    match_attr = '0;
    for (int i = `PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (match_list[i]) begin
        match_idx  = region_idx_t'(i);
        match_attr = region_attr_i[i];
      end
    end
  end

  // Size 0 byte, 1 half, 2 word
  always_comb begin
    case (trans_size_i)
      2'd0:    misaligned = 1'b0;
      2'd1:    misaligned = trans_addr_i[0];
      default: misaligned = |trans_addr_i[1:0];  // size 3 handled as word
    endcase
  end

  // Misaligned access only allowed in main memory
  assign allow = have_match && !(misaligned && !match_attr[`PMA_ATTR_MAIN]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status.valid <= 1'b0;
    end else begin
      status.valid <= accept;
    end
  end

  // Status fields load with each accepted transaction
  always_ff @(posedge clk) begin
    if (accept) begin
      status.have_match <= have_match;
      status.match_idx  <= match_idx;
      status.match_list <= match_list;
      status.attr       <= match_attr;
      status.allow      <= allow;
      status.misaligned <= misaligned;
      status.is_store   <= trans_we_i;
    end
  end

endmodule : pma_match

`default_nettype wire

// ==== logic/pma_pkg.sv ====
// --------------------
// Shared types of the PMA checker
// Vector typedefs, event counter select codes
// and the overlap helper
// --------------------
`default_nettype none

`include "pma_settings.svh"

package pma_pkg;

  typedef logic [`PMA_ADDR_W-1:0]              addr_t;
  typedef logic [`PMA_ATTR_W-1:0]              attr_t;
  typedef logic [$clog2(`PMA_NUM_REGIONS)-1:0] region_idx_t;
  typedef logic [`PMA_NUM_REGIONS-1:0]         match_list_t;
  typedef logic [`PMA_CNT_W-1:0]               evt_cnt_t;
  typedef logic [$clog2(`PMA_EVT_NUM)-1:0]     evt_sel_t;

  // Counter select codes
  // Codes 6 and 7 are unused and read as zero
  localparam evt_sel_t EVT_ACCEPTED   = 3'd0;
  localparam evt_sel_t EVT_NO_MATCH   = 3'd1;
  localparam evt_sel_t EVT_MULTI      = 3'd2;
  localparam evt_sel_t EVT_DENIED     = 3'd3;
  localparam evt_sel_t EVT_MISALIGNED = 3'd4;
  localparam evt_sel_t EVT_STORE      = 3'd5;

  // True when two or more regions hit
  // Clearing the lowest set bit leaves something only if another bit is set
  function automatic logic is_multi(match_list_t ml);
    match_list_t rest;
    rest = ml & (ml - 1'b1);
    return rest != '0;
  endfunction

endpackage : pma_pkg

`default_nettype wire

// ==== logic/pma_region_cfg.sv ====
// --------------------
// PMA region table
// Base, mask and attributes per region,
// one entry written per configuration strobe
// --------------------
`timescale 1ns/100ps
`default_nettype none

`include "pma_settings.svh"

module pma_region_cfg (
  input  wire                       clk,
  input  wire                       rst_n,

  // Configuration write port
  input  wire                       cfg_we_i,
  input  wire pma_pkg::region_idx_t cfg_idx_i,
  input  wire pma_pkg::addr_t       cfg_base_i,
  input  wire pma_pkg::addr_t       cfg_mask_i,
  input  wire pma_pkg::attr_t       cfg_attr_i,

  // Table contents towards the checker
  output pma_pkg::addr_t            region_base_o [`PMA_NUM_REGIONS],
  output pma_pkg::addr_t            region_mask_o [`PMA_NUM_REGIONS],
  output pma_pkg::attr_t            region_attr_o [`PMA_NUM_REGIONS]
);
  import pma_pkg::*;

  logic [`PMA_NUM_REGIONS-1:0] entry_we;

  // Decode the strobe into one enable per entry
  always_comb begin
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      entry_we[i] = cfg_we_i && (cfg_idx_i == region_idx_t'(i));
    end
  end

  // Every region comes out of reset invalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
        region_attr_o[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
        if (entry_we[i]) begin
          region_attr_o[i] <= cfg_attr_i;
        end
      end
    end
  end

  // Address match fields
  always_ff @(posedge clk) begin
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      if (entry_we[i]) begin
        region_base_o[i] <= cfg_base_i;
        region_mask_o[i] <= cfg_mask_i;
      end
    end
  end

endmodule : pma_region_cfg

`default_nettype wire

// ==== logic/pma_settings.svh ====
// --------------------
// Build settings of the PMA checker
// Region count, data widths and the
// bit positions inside the attribute vector
// --------------------
`ifndef PMA_SETTINGS_SVH
`define PMA_SETTINGS_SVH

`define PMA_NUM_REGIONS      4
`define PMA_ADDR_W           32
`define PMA_CNT_W            16
`define PMA_ATTR_W           5

// Attribute vector layout
`define PMA_ATTR_VALID       0
`define PMA_ATTR_MAIN        1
`define PMA_ATTR_BUFFERABLE  2
`define PMA_ATTR_CACHEABLE   3
`define PMA_ATTR_INTEGRITY   4

`define PMA_EVT_NUM          6

`endif

// ==== logic/pma_status_if.sv ====
// --------------------
// Checker status of one accepted transaction
// Producer, monitor and response views
// --------------------
`timescale 1ns/100ps
`default_nettype none

interface pma_status_if;
  import pma_pkg::*;

  logic        valid;
  logic        have_match;
  region_idx_t match_idx;
  match_list_t match_list;
  attr_t       attr;
  logic        allow;
  logic        misaligned;
  logic        is_store;

  // Driven by the match stage
  modport producer (
    output valid, have_match, match_idx, match_list, attr, allow, misaligned, is_store
  );

  // Event monitor view
  modport observer (
    input valid, have_match, match_idx, match_list, attr, allow, misaligned, is_store
  );

  // Response fields as seen by the top level
  modport resp (
    input valid, have_match, match_idx, match_list, attr, allow
  );

endinterface : pma_status_if

`default_nettype wire

// ==== logic/pma_top.sv ====
// --------------------
// PMA checker top level
// Region table, match stage and event
// monitor joined behind plain ports
// --------------------
`timescale 1ns/100ps
`default_nettype none

`include "pma_settings.svh"

module pma_top (
  input  wire                       clk,
  input  wire                       rst_n,

  // Region table configuration
  input  wire                       cfg_we_i,
  input  wire pma_pkg::region_idx_t cfg_idx_i,
  input  wire pma_pkg::addr_t       cfg_base_i,
  input  wire pma_pkg::addr_t       cfg_mask_i,
  input  wire pma_pkg::attr_t       cfg_attr_i,

  // Transaction request
  input  wire                       trans_valid_i,
  input  wire pma_pkg::addr_t       trans_addr_i,
  input  wire [1:0]                 trans_size_i,
  input  wire                       trans_we_i,
  output logic                      trans_ready_o,

  // Response, one cycle after acceptance
  output logic                      resp_valid_o,
  output logic                      resp_allow_o,
  output logic                      resp_hit_o,
  output pma_pkg::region_idx_t      resp_region_o,
  output pma_pkg::attr_t            resp_attr_o,
  output logic                      resp_multi_o,

  // Event counters
  input  wire                       cnt_clear_i,
  input  wire pma_pkg::evt_sel_t    cnt_sel_i,
  output pma_pkg::evt_cnt_t         cnt_value_o
);
  import pma_pkg::*;

  addr_t region_base [`PMA_NUM_REGIONS];
  addr_t region_mask [`PMA_NUM_REGIONS];
  attr_t region_attr [`PMA_NUM_REGIONS];

  pma_status_if status_if ();

  pma_region_cfg region_cfg0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_we_i      (cfg_we_i),
    .cfg_idx_i     (cfg_idx_i),
    .cfg_base_i    (cfg_base_i),
    .cfg_mask_i    (cfg_mask_i),
    .cfg_attr_i    (cfg_attr_i),
    .region_base_o (region_base),
    .region_mask_o (region_mask),
    .region_attr_o (region_attr)
  );

  pma_match match0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid_i),
    .trans_addr_i  (trans_addr_i),
    .trans_size_i  (trans_size_i),
    .trans_we_i    (trans_we_i),
    .trans_ready_o (trans_ready_o),
    .cfg_we_i      (cfg_we_i),
    .region_base_i (region_base),
    .region_mask_i (region_mask),
    .region_attr_i (region_attr),
    .status        (status_if.producer)
  );

  pma_event_monitor event_monitor0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .cnt_clear_i (cnt_clear_i),
    .cnt_sel_i   (cnt_sel_i),
    .status      (status_if.observer),
    .cnt_value_o (cnt_value_o)
  );

  // Response fields straight from the status register
  assign resp_valid_o  = status_if.valid;
  assign resp_allow_o  = status_if.allow;
  assign resp_hit_o    = status_if.have_match;
  assign resp_region_o = status_if.match_idx;
  assign resp_attr_o   = status_if.attr;
  assign resp_multi_o  = is_multi(status_if.match_list);

endmodule : pma_top

`default_nettype wire

// ==== verif/pma_input.txt ====
# C idx base mask attr | T addr size we exp_allow exp_hit exp_region exp_attr exp_multi
# R select exp_count | X clear counters | all fields hex
T 00001000 2 0 0 0 0 00 0
T 80000003 1 1 0 0 0 00 0
R 0 2
R 1 2
X
C 0 10000000 F0000000 0B
C 1 10000000 FFFF0000 01
C 2 20000000 F0000000 07
C 3 10000000 FF000000 01
T 10001000 2 0 1 1 0 0B 1
T 10400000 2 1 1 1 0 0B 1
T 20000010 2 0 1 1 2 07 0
T 30000000 2 0 0 0 0 00 0
C 0 00000000 00000000 00
T 10001000 2 0 1 1 1 01 1
R 2 3
X
T 20000001 1 0 1 1 2 07 0
T 20000002 2 0 1 1 2 07 0
T 10000001 1 0 0 1 1 01 1
T 10800002 2 1 0 1 3 01 0
T 10800003 0 0 1 1 3 01 0
T 10000004 2 0 1 1 1 01 1
R 4 4
R 3 2
R 5 1
R 2 2
R 6 0
X
R 7 0
R 0 0

// ==== verif/tb_pma_top.sv ====
// --------------------
// Testbench of the PMA checker
// Records from the input file, reference model,
// random phase and error summary
// --------------------
`timescale 1ns/100ps
`default_nettype none

`include "pma_settings.svh"

module tb_pma_top;
  import pma_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int N_RAND       = 200;

  typedef logic [7:0][31:0] rec_t;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        cfg_we_i = 1'b0;
  region_idx_t cfg_idx_i = '0;
  addr_t       cfg_base_i = '0;
  addr_t       cfg_mask_i = '0;
  attr_t       cfg_attr_i = '0;
  logic        trans_valid_i = 1'b0;
  addr_t       trans_addr_i = '0;
  logic [1:0]  trans_size_i = '0;
  logic        trans_we_i = 1'b0;
  logic        cnt_clear_i = 1'b0;
  evt_sel_t    cnt_sel_i = '0;
  logic        trans_ready_o, resp_valid_o, resp_allow_o, resp_hit_o, resp_multi_o;
  region_idx_t resp_region_o;
  attr_t       resp_attr_o;
  evt_cnt_t    cnt_value_o;

  // Model of the table, the counters and the response in flight
  addr_t       m_base [`PMA_NUM_REGIONS];
  addr_t       m_mask [`PMA_NUM_REGIONS];
  attr_t       m_attr [`PMA_NUM_REGIONS] = '{default: '0};
  evt_cnt_t    m_cnt [8] = '{default: '0};
  logic        pend = 1'b0;
  logic        p_allow, p_hit, p_multi, p_mis, p_store;
  region_idx_t p_region;
  attr_t       p_attr;

  logic [7:0]  kind_q [$];
  rec_t        fld_q [$];
  rec_t        fl;
  logic [31:0] v [8];
  string       line, tag;
  integer      fd;
  integer      seed = 33971;
  addr_t       addr;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          limit = 100000;

  always #20 clk = ~clk;

  pma_top dut0 (.*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Inputs for the coming cycle, applied right after the rising edge
  task automatic drive(input logic tv, input addr_t a, input logic [1:0] sz, input logic we,
                       input logic cw, input logic clr);
    @(posedge clk);
    trans_valid_i <= tv;
    trans_addr_i  <= a;
    trans_size_i  <= sz;
    trans_we_i    <= we;
    cfg_we_i      <= cw;
    cnt_clear_i   <= clr;
  endtask

  // Expected response from the matching rules
  task automatic predict(input addr_t a, input logic [1:0] size, input logic we);
    int          hits;
    logic [31:0] bytes;
    hits     = 0;
    p_region = '0;
    p_attr   = '0;
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      if (m_attr[i][`PMA_ATTR_VALID] && (a & m_mask[i]) == m_base[i]) begin
        if (hits == 0) begin
          p_region = region_idx_t'(i);
          p_attr   = m_attr[i];
        end
        hits++;
      end
    end
    bytes   = (size == 2'd0) ? 32'd1 : (size == 2'd1) ? 32'd2 : 32'd4;
    p_hit   = hits > 0;
    p_multi = hits > 1;
    p_mis   = (a % bytes) != 0;
    p_allow = p_hit && (!p_mis || p_attr[`PMA_ATTR_MAIN]);
    p_store = we;
  endtask

  // Check outputs mid cycle, then step the model past the next edge
  task automatic settle(input string tag);
    @(negedge clk);
    compare({tag, " resp_valid"}, 32'(pend), 32'(resp_valid_o));
    if (pend) begin
      compare({tag, " resp {allow,hit,region,attr,multi}"},
              32'({p_allow, p_hit, p_region, p_attr, p_multi}),
              32'({resp_allow_o, resp_hit_o, resp_region_o, resp_attr_o, resp_multi_o}));
    end
    compare({tag, " ready"}, 32'(!cfg_we_i), 32'(trans_ready_o));
    if (cnt_clear_i) begin
      foreach (m_cnt[i]) m_cnt[i] = '0;
    end else if (pend) begin
      m_cnt[EVT_ACCEPTED]   = m_cnt[EVT_ACCEPTED] + evt_cnt_t'(1);
      m_cnt[EVT_NO_MATCH]   = m_cnt[EVT_NO_MATCH] + evt_cnt_t'(!p_hit);
      m_cnt[EVT_MULTI]      = m_cnt[EVT_MULTI] + evt_cnt_t'(p_multi);
      m_cnt[EVT_DENIED]     = m_cnt[EVT_DENIED] + evt_cnt_t'(!p_allow);
      m_cnt[EVT_MISALIGNED] = m_cnt[EVT_MISALIGNED] + evt_cnt_t'(p_mis);
      m_cnt[EVT_STORE]      = m_cnt[EVT_STORE] + evt_cnt_t'(p_store);
    end
    pend = trans_valid_i && !cfg_we_i;
    if (pend) begin
      predict(trans_addr_i, trans_size_i, trans_we_i);
    end
    if (cfg_we_i) begin
      m_base[cfg_idx_i] = cfg_base_i;
      m_mask[cfg_idx_i] = cfg_mask_i;
      m_attr[cfg_idx_i] = cfg_attr_i;
    end
  endtask

  // Idle cycle lets a pending response reach the counters first
  task automatic read_counter(input evt_sel_t sel, input string tag);
    drive(1'b0, '0, 2'd0, 1'b0, 1'b0, 1'b0);
    cnt_sel_i <= sel;
    settle(tag);
    drive(1'b0, '0, 2'd0, 1'b0, 1'b0, 1'b0);
    settle(tag);
    compare({tag, " count"}, 32'(m_cnt[sel]), 32'(cnt_value_o));
  endtask

  initial begin
    fd = $fopen("verif/pma_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verif/pma_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          foreach (v[i]) v[i] = '0;
          void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]));
          foreach (v[i]) fl[i] = v[i];
          kind_q.push_back(line[0]);
          fld_q.push_back(fl);
        end
      end
      $fclose(fd);
    end
    limit = 4 * kind_q.size() + N_RAND + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    foreach (kind_q[n]) begin
      fl  = fld_q[n];
      tag = $sformatf("record %0d", n);
      case (kind_q[n])
        "C": begin
          // A transaction is offered too and must be held off
          drive(1'b1, fl[1], 2'd2, 1'b0, 1'b1, 1'b0);
          cfg_idx_i  <= region_idx_t'(fl[0]);
          cfg_base_i <= fl[1];
          cfg_mask_i <= fl[2];
          cfg_attr_i <= attr_t'(fl[3]);
          settle(tag);
        end
        "T": begin
          drive(1'b1, fl[0], fl[1][1:0], fl[2][0], 1'b0, 1'b0);
          settle(tag);
          compare({tag, " file vs model"},
                  32'({fl[3][0], fl[4][0], fl[5][1:0], fl[6][4:0], fl[7][0]}),
                  32'({p_allow, p_hit, p_region, p_attr, p_multi}));
        end
        "R": begin
          read_counter(evt_sel_t'(fl[0]), tag);
          compare({tag, " file count"}, fl[1], 32'(cnt_value_o));
        end
        "X": begin
          drive(1'b0, '0, 2'd0, 1'b0, 1'b0, 1'b1);
          settle(tag);
        end
        default: begin
          $display("Unknown record kind in the stimulus file at record %0d", n);
          errors++;
        end
      endcase
    end

    // Region 0 with every attribute bit set covers the whole attribute vector
    drive(1'b1, '0, 2'd2, 1'b0, 1'b1, 1'b0);
    cfg_idx_i  <= '0;
    cfg_base_i <= '0;
    cfg_mask_i <= 32'hF000_0000;
    cfg_attr_i <= '1;
    settle("random table setup");

    // Random traffic steered towards the regions
    for (int k = 0; k < N_RAND; k++) begin
      addr = $random(seed);
      addr[31:30] = 2'b00;
      if (addr[27]) begin
        addr[27:16] = '0;
      end
      drive(1'b1, addr, 2'($unsigned($random(seed)) % 3), 1'($random(seed)), 1'b0, 1'b0);
      settle($sformatf("random %0d", k));
    end
    for (int s = 0; s < 8; s++) begin
      read_counter(evt_sel_t'(s), $sformatf("final select %0d", s));
    end

    $display("Summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tb_pma_top

`default_nettype wire
